//--- flist.f
src/cpuPkg.sv
src/insnDecoder.sv
src/regFile.sv
src/execUnit.sv
src/resultStage.sv
src/cpuCore.sv
test/cpuCoreTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = cpuCoreTb
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- test/cpuCoreTb.sv
`timescale 1ns/1ns

module cpuCoreTb;

    localparam int            M_ALU     = 0;
    localparam int            M_SWAP    = 1;   // Immediate on the right and Y as addend
    localparam int            M_LOAD    = 2;
    localparam int            M_BRANCH  = 3;
    localparam int            M_ALIAS   = 4;
    localparam int            HALT_WAIT = 200;
    localparam cpuPkg::word_t ILLEGAL   = 32'hffff_ffff;
    localparam cpuPkg::word_t ONES      = 32'hffff_ffff;

    typedef struct {
        string          name;
        cpuPkg::aluOp_t op;
        logic [11:0]    left;
        logic [11:0]    right;
        logic [11:0]    add;
        int             mode;
        cpuPkg::word_t  expWord;   // First stored word
    } testRow_t;

    logic          clk;
    logic          reset_n;
    cpuPkg::word_t iAddr;
    cpuPkg::word_t iData;
    cpuPkg::word_t dAddr;
    cpuPkg::word_t wData;
    cpuPkg::word_t rData;
    logic          strobe;
    logic          memRw;
    logic          halt;
    cpuPkg::word_t imem [64];
    cpuPkg::word_t dmem [64];
    cpuPkg::word_t storeAddrs [$];
    cpuPkg::word_t storeData [$];
    cpuPkg::word_t readAddrs [$];
    logic [63:0]   reached;        // Fetch addresses seen since reset
    testRow_t      rows [$];
    cpuPkg::word_t lfsr = 32'ha25f_c437;
    int            mismatches = 0;
    int            timeouts = 0;

    assign iData = imem[iAddr[5:0]];
    assign rData = dmem[dAddr[5:0]];

    cpuCore DUT (
        .clk(clk), .reset_n(reset_n), .iAddr(iAddr), .iData(iData), .dAddr(dAddr),
        .wData(wData), .rData(rData), .strobe(strobe), .memRw(memRw), .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Bus log sampled mid-cycle
    always @(negedge clk) begin
        if (!reset_n) begin
            storeAddrs.delete();
            storeData.delete();
            readAddrs.delete();
            reached = '0;
        end else begin
            if (strobe && memRw) begin
                storeAddrs.push_back(dAddr);
                storeData.push_back(wData);
            end
            if (strobe && !memRw) begin
                readAddrs.push_back(dAddr);
            end
            if (iAddr < 64) begin
                reached[iAddr[5:0]] = 1'b1;
            end
        end
    end

    function automatic cpuPkg::word_t takeBits(int n);
        cpuPkg::word_t v;
        logic          b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);   // Galois step
            v    = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic cpuPkg::word_t sext(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic cpuPkg::word_t memFill(cpuPkg::word_t a);
        return (a * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic cpuPkg::word_t enc(logic t, logic s, logic d, cpuPkg::regIdx_t z,
            cpuPkg::regIdx_t x, cpuPkg::regIdx_t y, cpuPkg::aluOp_t op, logic [11:0] imm);
        return {1'b0, t, s, d, z, x, y, op, imm};
    endfunction

    function automatic cpuPkg::word_t li(cpuPkg::regIdx_t z, logic [11:0] imm);
        return enc(1'b0, 1'b0, 1'b0, z, 4'd0, 4'd0, cpuPkg::OP_OR, imm);   // z = r0 | r0 + imm
    endfunction

    function automatic cpuPkg::word_t st(cpuPkg::regIdx_t z, logic [11:0] addr);
        return enc(1'b0, 1'b1, 1'b1, z, 4'd0, 4'd0, cpuPkg::OP_OR, addr);
    endfunction

    // Reference x op y with signed compares
    function automatic cpuPkg::word_t aluRef(cpuPkg::aluOp_t op, cpuPkg::word_t a,
            cpuPkg::word_t b);
        case (op)
            cpuPkg::OP_OR:   return a | b;
            cpuPkg::OP_AND:  return a & b;
            cpuPkg::OP_ADD:  return a + b;
            cpuPkg::OP_MUL:  return a * b;
            cpuPkg::OP_SHL:  return a << b;
            cpuPkg::OP_LT:   return ($signed(a) < $signed(b)) ? ONES : '0;
            cpuPkg::OP_EQ:   return (a == b) ? ONES : '0;
            cpuPkg::OP_GT:   return ($signed(a) > $signed(b)) ? ONES : '0;
            cpuPkg::OP_ANDN: return a & ~b;
            cpuPkg::OP_XOR:  return a ^ b;
            cpuPkg::OP_SUB:  return a - b;
            cpuPkg::OP_XNOR: return ~(a ^ b);
            cpuPkg::OP_SHR:  return a >> b;
            cpuPkg::OP_NE:   return (a != b) ? ONES : '0;
            default:         return '0;   // Both reserved codes
        endcase
    endfunction

    task automatic checkWord(string name, cpuPkg::word_t exp, cpuPkg::word_t act);
        if (act !== exp) begin
            mismatches++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkFlag(string name, logic exp, logic act);
        if (act !== exp) begin
            mismatches++;
            $display("ERR %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic addRow(string name, cpuPkg::aluOp_t op, logic [11:0] l, logic [11:0] r,
            logic [11:0] a, int mode, cpuPkg::word_t expWord);
        testRow_t row;
        row.name    = name;
        row.op      = op;
        row.left    = l;
        row.right   = r;
        row.add     = a;
        row.mode    = mode;
        row.expWord = expWord;
        rows.push_back(row);
    endtask

    task automatic runRow(testRow_t row);
        cpuPkg::word_t expData [$];
        cpuPkg::word_t l;
        int            cycles;
        int            atHalt;
        logic          held;
        l = sext(row.left);
        @(negedge clk);
        reset_n = 1'b0;
        foreach (imem[i]) imem[i] = ILLEGAL;   // Program falls through into a halt
        case (row.mode)
            M_LOAD: begin
                imem[0] = enc(1'b0, 1'b0, 1'b1, 4'd4, 4'd0, 4'd0, cpuPkg::OP_OR, row.left);
                imem[1] = st(4'd4, 12'd40);
                expData.push_back(row.expWord);
            end
            M_BRANCH: begin
                imem[0] = li(4'd1, row.left);
                imem[1] = li(4'd2, row.right);   // Poison
                imem[2] = li(4'd15, 12'd4);      // Jump over address 3
                imem[3] = st(4'd2, 12'd40);
                imem[4] = st(4'd1, 12'd40);
                expData.push_back(row.expWord);
            end
            M_ALIAS: begin
                imem[0] = li(4'd0, row.left);
                imem[1] = st(4'd0, 12'd40);
                imem[2] = st(4'd15, 12'd41);     // Own address plus one
                expData.push_back(row.expWord);
                expData.push_back(32'd3);
            end
            default: begin
                imem[0] = li(4'd1, row.left);
                if (row.mode == M_SWAP) begin
                    imem[1] = li(4'd2, row.add);
                    imem[2] = enc(1'b1, 1'b0, 1'b0, 4'd3, 4'd1, 4'd2, row.op, row.right);
                end else begin
                    imem[1] = li(4'd2, row.right);
                    imem[2] = enc(1'b0, 1'b0, 1'b0, 4'd3, 4'd1, 4'd2, row.op, row.add);
                end
                imem[3] = st(4'd3, 12'd40);
                expData.push_back(row.expWord);
            end
        endcase
        repeat (5) @(negedge clk);
        checkWord({row.name, ".resetIAddr"}, cpuPkg::RESET_VECTOR, iAddr);
        checkFlag({row.name, ".resetStrobe"}, 1'b0, strobe);
        checkFlag({row.name, ".resetMemRw"}, 1'b0, memRw);
        checkFlag({row.name, ".resetHalt"}, 1'b0, halt);
        reset_n = 1'b1;
        cycles = 0;
        while (halt !== 1'b1 && cycles < HALT_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (halt !== 1'b1) begin
            timeouts++;
            $display("Timeout in %s: halt never came up", row.name);
        end
        atHalt = storeData.size();
        held = 1'b1;
        repeat (20) begin
            @(negedge clk);
            held &= halt;
        end
        checkFlag({row.name, ".haltHeld"}, 1'b1, held);
        checkWord({row.name, ".storesAfterHalt"}, atHalt, storeData.size());
        checkWord({row.name, ".stores"}, expData.size(), storeData.size());
        foreach (expData[i]) begin
            if (i < storeData.size()) begin
                checkWord({row.name, ".dAddr"}, 32'd40 + i, storeAddrs[i]);
                checkWord({row.name, ".wData"}, expData[i], storeData[i]);
            end
        end
        checkWord({row.name, ".reads"}, (row.mode == M_LOAD) ? 32'd1 : 32'd0, readAddrs.size());
        if (row.mode == M_LOAD && readAddrs.size() > 0) begin
            checkWord({row.name, ".readAddr"}, l, readAddrs[0]);
        end
        if (row.mode == M_BRANCH) begin
            checkFlag({row.name, ".target"}, 1'b1, reached[4]);
            checkFlag({row.name, ".skipped"}, 1'b0, reached[3]);
        end
    endtask

    initial begin
        cpuPkg::aluOp_t rndOp;
        logic [11:0]    rndLeft;
        logic [11:0]    rndRight;
        logic [11:0]    rndAdd;
        int             rndMode;
        reset_n = 1'b0;
        foreach (imem[i]) imem[i] = ILLEGAL;
        foreach (dmem[i]) dmem[i] = memFill(i);
        addRow("or", cpuPkg::OP_OR, 12'h0f0, 12'h00f, 12'h000, M_ALU, 32'h0000_00ff);
        addRow("and", cpuPkg::OP_AND, 12'h0ff, 12'h0f0, 12'h001, M_ALU, 32'h0000_00f1);
        addRow("add", cpuPkg::OP_ADD, 12'h7ff, 12'h001, 12'h010, M_ALU, 32'h0000_0810);
        addRow("mul", cpuPkg::OP_MUL, 12'h123, 12'h045, 12'h000, M_ALU, 32'h0000_4e6f);
        addRow("rsv4", cpuPkg::OP_RSV4, 12'h555, 12'h0aa, 12'h000, M_ALU, 32'h0000_0000);
        addRow("shl", cpuPkg::OP_SHL, 12'h001, 12'h01f, 12'h000, M_ALU, 32'h8000_0000);
        addRow("lt", cpuPkg::OP_LT, 12'hff0, 12'h005, 12'h000, M_ALU, 32'hffff_ffff);   // -16 < 5
        addRow("eq", cpuPkg::OP_EQ, 12'h042, 12'h042, 12'h001, M_ALU, 32'h0000_0000);
        addRow("gt", cpuPkg::OP_GT, 12'h005, 12'hff0, 12'h000, M_ALU, 32'hffff_ffff);
        addRow("andn", cpuPkg::OP_ANDN, 12'hfff, 12'h0f0, 12'h000, M_ALU, 32'hffff_ff0f);
        addRow("xor", cpuPkg::OP_XOR, 12'ha5a, 12'h5a5, 12'h000, M_ALU, 32'hffff_ffff);
        addRow("sub", cpuPkg::OP_SUB, 12'h010, 12'h020, 12'h000, M_ALU, 32'hffff_fff0);
        addRow("xnor", cpuPkg::OP_XNOR, 12'h0f0, 12'h00f, 12'h000, M_ALU, 32'hffff_ff00);
        addRow("shr", cpuPkg::OP_SHR, 12'h800, 12'h004, 12'h000, M_ALU, 32'h0fff_ff80);
        addRow("ne", cpuPkg::OP_NE, 12'h001, 12'h002, 12'h002, M_ALU, 32'h0000_0001);
        addRow("rsv15", cpuPkg::OP_RSV15, 12'hfff, 12'hfff, 12'h000, M_ALU, 32'h0000_0000);
        addRow("swapSub", cpuPkg::OP_SUB, 12'h100, 12'h7ff, 12'h003, M_SWAP, 32'hffff_f904);
        addRow("swapLt", cpuPkg::OP_LT, 12'h800, 12'h7ff, 12'h000, M_SWAP, 32'hffff_ffff);
        addRow("load", cpuPkg::OP_OR, 12'd17, 12'h000, 12'h000, M_LOAD, memFill(32'd17));
        addRow("branch", cpuPkg::OP_OR, 12'h3c3, 12'hbad, 12'h000, M_BRANCH, 32'h0000_03c3);
        addRow("alias", cpuPkg::OP_OR, 12'h777, 12'h000, 12'h000, M_ALIAS, 32'h0000_0000);
        for (int i = 0; i < 8; i++) begin
            rndOp    = cpuPkg::aluOp_t'(takeBits(4));
            rndLeft  = 12'(takeBits(12));
            rndRight = 12'(takeBits(12));
            rndAdd   = 12'(takeBits(12));
            rndMode  = (takeBits(1) != 0) ? M_SWAP : M_ALU;
            addRow($sformatf("random%0d", i), rndOp, rndLeft, rndRight, rndAdd, rndMode,
                aluRef(rndOp, sext(rndLeft), sext(rndRight)) + sext(rndAdd));
        end
        foreach (rows[i]) runRow(rows[i]);
        $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- src/cpuCore.sv
`timescale 1ns/1ns

module cpuCore (
    input  logic          clk,
    input  logic          reset_n,
    output cpuPkg::word_t iAddr,
    input  cpuPkg::word_t iData,
    output cpuPkg::word_t dAddr,
    output cpuPkg::word_t wData,
    input  cpuPkg::word_t rData,
    output logic          strobe,
    output logic          memRw,
    output logic          halt
);

    cpuPkg::phase_t       phase;
    logic                 running;     // Low for the idle cycle after reset
    logic                 active;
    logic                 exEn;
    cpuPkg::word_t        insn;
    cpuPkg::word_t        nextPc;      // Fetch address plus one
    cpuPkg::word_t        fetchNext;
    cpuPkg::decodedInsn_t dec;
    cpuPkg::word_t        valueX;
    cpuPkg::word_t        valueY;
    cpuPkg::word_t        valueZ;
    cpuPkg::word_t        rightOp;
    cpuPkg::word_t        addend;
    cpuPkg::word_t        aluOut;
    cpuPkg::word_t        rhs;
    logic                 upZ;

    assign active    = running && !halt;
    assign exEn      = active && (phase == cpuPkg::PH_EXEC);
    assign fetchNext = dec.branch ? rhs : nextPc;

    // Immediate swaps places with Y
    assign rightOp = dec.immType ? dec.imm : valueY;
    assign addend  = dec.immType ? valueY : dec.imm;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase   <= cpuPkg::PH_FETCH;
            running <= 1'b0;
            halt    <= 1'b0;
            insn    <= cpuPkg::INSN_NOOP;
            iAddr   <= cpuPkg::RESET_VECTOR;
            nextPc  <= cpuPkg::RESET_VECTOR + 32'd1;
        end else if (!running) begin
            running <= 1'b1;
        end else if (active) begin
            case (phase)
                cpuPkg::PH_FETCH: begin
                    insn  <= iData;
                    phase <= cpuPkg::PH_EXEC;
                end
                cpuPkg::PH_EXEC: begin
                    if (dec.illegal) begin
                        halt  <= 1'b1;               // Park in fetch for good
                        phase <= cpuPkg::PH_FETCH;
                    end else begin
                        phase <= cpuPkg::PH_MEM;
                    end
                end
                cpuPkg::PH_MEM: phase <= cpuPkg::PH_WRITE;
                cpuPkg::PH_WRITE: begin
                    iAddr  <= fetchNext;
                    nextPc <= fetchNext + 32'd1;
                    phase  <= cpuPkg::PH_FETCH;
                end
                default: phase <= cpuPkg::PH_FETCH;
            endcase
        end
    end

    insnDecoder decoder (.insn(insn), .dec(dec));

    regFile regs (
        .clk(clk), .reset_n(reset_n), .en(active), .upZ(upZ),
        .indexX(dec.x), .indexY(dec.y), .indexZ(dec.z),
        .writeZ(rhs), .nextPc(nextPc),
        .valueX(valueX), .valueY(valueY), .valueZ(valueZ)
    );

    execUnit exec (
        .clk(clk), .reset_n(reset_n), .en(exEn), .op(dec.op),
        .x(valueX), .y(rightOp), .addend(addend), .aluOut(aluOut)
    );

    resultStage result (
        .clk(clk), .reset_n(reset_n), .en(active), .phase(phase), .dec(dec),
        .aluOut(aluOut), .valueZ(valueZ), .rData(rData),
        .dAddr(dAddr), .wData(wData), .rhs(rhs),
        .strobe(strobe), .memRw(memRw), .upZ(upZ)
    );

endmodule

//--- src/resultStage.sv
`timescale 1ns/1ns

module resultStage (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 en,
    input  cpuPkg::phase_t       phase,
    input  cpuPkg::decodedInsn_t dec,
    input  cpuPkg::word_t        aluOut,
    input  cpuPkg::word_t        valueZ,
    input  cpuPkg::word_t        rData,
    output cpuPkg::word_t        dAddr,
    output cpuPkg::word_t        wData,
    output cpuPkg::word_t        rhs,
    output logic                 strobe,
    output logic                 memRw,
    output logic                 upZ
);

    cpuPkg::word_t loadData;   // Read word held for write-back
    logic          loading;
    logic          loadStrobe;
    logic          storeStrobe;

    assign loading     = dec.derefRhs && !dec.storing;
    assign loadStrobe  = en && loading && (phase == cpuPkg::PH_MEM);
    assign storeStrobe = en && dec.storing && (phase == cpuPkg::PH_WRITE);

    assign strobe = loadStrobe || storeStrobe;
    assign memRw  = storeStrobe;

    // With derefRhs the ALU gives the address, otherwise Z does
    assign dAddr = dec.derefRhs ? aluOut : valueZ;
    assign wData = dec.derefRhs ? valueZ : aluOut;

    always_ff @(posedge clk) begin
        if (loadStrobe) begin
            loadData <= rData;   // End of PH_MEM
        end
    end

    assign rhs = dec.derefRhs ? loadData : aluOut;

    // Stores never write back
    assign upZ = en && !dec.storing && (phase == cpuPkg::PH_WRITE);

    // Latched load data is written back in the very next phase
    assert property (@(posedge clk) disable iff (!reset_n)
        loadStrobe |=> (phase == cpuPkg::PH_WRITE) && $stable(dec))
        else $error("resultStage load not followed by its write-back");

endmodule

//--- src/execUnit.sv
`timescale 1ns/1ns

module execUnit (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           en,
    input  cpuPkg::aluOp_t op,
    input  cpuPkg::word_t  x,
    input  cpuPkg::word_t  y,
    input  cpuPkg::word_t  addend,
    output cpuPkg::word_t  aluOut
);

    cpuPkg::word_t opResult;
    logic          isLess;
    logic          isGreater;
    logic          isEqual;

    // Compares see the operands as two's complement
    assign isLess    = $signed(x) < $signed(y);
    assign isGreater = $signed(x) > $signed(y);
    assign isEqual   = x == y;

    always_comb begin
        case (op)
            cpuPkg::OP_OR:    opResult = x | y;
            cpuPkg::OP_AND:   opResult = x & y;
            cpuPkg::OP_ADD:   opResult = x + y;
            cpuPkg::OP_MUL:   opResult = x * y;   // Low word only
            cpuPkg::OP_SHL:   opResult = x << y;
            cpuPkg::OP_LT:    opResult = {cpuPkg::WORD_W{isLess}};
            cpuPkg::OP_EQ:    opResult = {cpuPkg::WORD_W{isEqual}};
            cpuPkg::OP_GT:    opResult = {cpuPkg::WORD_W{isGreater}};
            cpuPkg::OP_ANDN:  opResult = x & ~y;
            cpuPkg::OP_XOR:   opResult = x ^ y;
            cpuPkg::OP_SUB:   opResult = x - y;
            cpuPkg::OP_XNOR:  opResult = x ^ ~y;
            cpuPkg::OP_SHR:   opResult = x >> y;
            cpuPkg::OP_NE:    opResult = {cpuPkg::WORD_W{!isEqual}};
            cpuPkg::OP_RSV4,
            cpuPkg::OP_RSV15: opResult = '0;      // Reserved codes
            default:          opResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            aluOut <= opResult + addend;
        end
    end

    // One execute cycle per instruction
    assert property (@(posedge clk) disable iff (!reset_n) en |=> !en)
        else $error("execUnit enabled on back-to-back cycles");

endmodule

//--- src/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            en,
    input  logic            upZ,
    input  cpuPkg::regIdx_t indexX,
    input  cpuPkg::regIdx_t indexY,
    input  cpuPkg::regIdx_t indexZ,
    input  cpuPkg::word_t   writeZ,
    input  cpuPkg::word_t   nextPc,
    output cpuPkg::word_t   valueX,
    output cpuPkg::word_t   valueY,
    output cpuPkg::word_t   valueZ
);

    cpuPkg::word_t regs [1:14];   // r0 and r15 are aliases
    logic          zIsAlias;

    assign zIsAlias = (indexZ == cpuPkg::REG_ZERO) || (indexZ == cpuPkg::REG_PC);

    assign valueX = (indexX == cpuPkg::REG_ZERO) ? '0 :
                    (indexX == cpuPkg::REG_PC)   ? nextPc : regs[indexX];
    assign valueY = (indexY == cpuPkg::REG_ZERO) ? '0 :
                    (indexY == cpuPkg::REG_PC)   ? nextPc : regs[indexY];
    assign valueZ = (indexZ == cpuPkg::REG_ZERO) ? '0 :
                    (indexZ == cpuPkg::REG_PC)   ? nextPc : regs[indexZ];

    always_ff @(posedge clk) begin
        if (en && upZ && !zIsAlias) begin
            regs[indexZ] <= writeZ;
        end
    end

    // A written register reads back its new value while Z stays put
    assert property (@(posedge clk) disable iff (!reset_n)
        en && upZ && !zIsAlias |=>
            (indexZ != $past(indexZ)) || (valueZ == $past(writeZ)))
        else $error("regFile r%0d did not read back its write", indexZ);

endmodule

//--- src/insnDecoder.sv
`timescale 1ns/1ns

module insnDecoder (
    input  cpuPkg::word_t        insn,
    output cpuPkg::decodedInsn_t dec
);

    logic [cpuPkg::IMM_W-1:0] immField;

    assign immField = insn[cpuPkg::IMM_W-1:0];

    always_comb begin
        dec.immType  = insn[cpuPkg::TYPE_BIT];
        dec.storing  = insn[cpuPkg::STORE_BIT];
        dec.derefRhs = insn[cpuPkg::DEREF_BIT];
        dec.z        = insn[cpuPkg::Z_LSB +: cpuPkg::REG_IDX_W];
        dec.x        = insn[cpuPkg::X_LSB +: cpuPkg::REG_IDX_W];
        dec.y        = insn[cpuPkg::Y_LSB +: cpuPkg::REG_IDX_W];
        dec.op       = insn[cpuPkg::OP_LSB +: cpuPkg::OP_W];

        // Sign extension of the 12-bit field
        dec.imm = {{(cpuPkg::WORD_W - cpuPkg::IMM_W){immField[cpuPkg::IMM_W-1]}}, immField};

        // All ones is the halt pattern
        dec.illegal = &insn;

        // Writing r15 is a jump, storing from it is not
        dec.branch = (dec.z == cpuPkg::REG_PC) && !dec.storing;
    end

endmodule

//--- src/cpuPkg.sv
package cpuPkg;

    localparam int WORD_W     = 32;
    localparam int REG_IDX_W  = 4;
    localparam int OP_W       = 4;
    localparam int NUM_PHASES = 4;   // Cycles per instruction

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] regIdx_t;
    typedef logic [OP_W-1:0]      aluOp_t;

    // Bit positions inside the instruction word
    localparam int TYPE_BIT  = 30;
    localparam int STORE_BIT = 29;
    localparam int DEREF_BIT = 28;
    localparam int Z_LSB     = 24;
    localparam int X_LSB     = 20;
    localparam int Y_LSB     = 16;
    localparam int OP_LSB    = 12;
    localparam int IMM_W     = 12;   // Sign-extended to a word

    localparam aluOp_t OP_OR    = 4'h0;
    localparam aluOp_t OP_AND   = 4'h1;
    localparam aluOp_t OP_ADD   = 4'h2;
    localparam aluOp_t OP_MUL   = 4'h3;
    localparam aluOp_t OP_RSV4  = 4'h4;
    localparam aluOp_t OP_SHL   = 4'h5;
    localparam aluOp_t OP_LT    = 4'h6;   // Signed
    localparam aluOp_t OP_EQ    = 4'h7;
    localparam aluOp_t OP_GT    = 4'h8;   // Signed
    localparam aluOp_t OP_ANDN  = 4'h9;
    localparam aluOp_t OP_XOR   = 4'ha;
    localparam aluOp_t OP_SUB   = 4'hb;
    localparam aluOp_t OP_XNOR  = 4'hc;
    localparam aluOp_t OP_SHR   = 4'hd;   // Logical
    localparam aluOp_t OP_NE    = 4'he;
    localparam aluOp_t OP_RSV15 = 4'hf;

    localparam regIdx_t REG_ZERO = 4'd0;
    localparam regIdx_t REG_PC   = 4'd15;

    localparam word_t RESET_VECTOR = 32'h0000_0000;
    localparam word_t INSN_NOOP    = 32'h0000_0000;   // r0 <- r0 | r0

    typedef struct packed {
        logic    immType;    // Immediate replaces Y, Y becomes addend
        logic    storing;
        logic    derefRhs;
        regIdx_t z;
        regIdx_t x;
        regIdx_t y;
        aluOp_t  op;
        word_t   imm;
        logic    illegal;
        logic    branch;     // Result goes to the PC
    } decodedInsn_t;

    typedef enum logic [$clog2(NUM_PHASES)-1:0] {
        PH_FETCH,
        PH_EXEC,
        PH_MEM,
        PH_WRITE
    } phase_t;

endpackage
